// File: fp_vector_add.f
rtl/fp_add_pkg.sv
rtl/fp_align_stage.sv
rtl/fp_add_stage.sv
rtl/fp_lzd_stage.sv
rtl/fp_normalize_stage.sv
rtl/fp_vector_add.sv
tests/fp_vector_add_tb.sv

// File: Bender.yml
package:
  name: fp_vector_add

sources:
  # Package first, then the stages in pipeline order, then the top level
  - rtl/fp_add_pkg.sv
  - rtl/fp_align_stage.sv
  - rtl/fp_add_stage.sv
  - rtl/fp_lzd_stage.sv
  - rtl/fp_normalize_stage.sv
  - rtl/fp_vector_add.sv

  # Testbench only in simulation
  - target: simulation
    files:
      - tests/fp_vector_add_tb.sv

// File: tests/fp_vector_add_tb.sv
/*
 Checks the four-lane add/subtract pipeline against a model of its arithmetic rules
 Operands never use exponent 255 and every result is expected exactly four cycles after issue
*/
`timescale 1ns/10ps

module fp_vector_add_tb;
	// 100 ns clock period
	localparam int half_period = 50;
	localparam int latency = 4;
	// About four times the roughly 450 cycles the tests take
	localparam int timeout_cycles = 2000;

	// One pending issue with its expected sideband, words and issue cycle
	typedef struct packed
	{
		logic [7:0] tag;
		fp_add_pkg::fp_op_t op;
		logic [fp_add_pkg::lanes-1:0] mask;
		logic [fp_add_pkg::lanes-1:0][31:0] words;
		logic [31:0] cycle;
	} expect_t;

	logic clk;
	logic reset;
	fp_add_pkg::issue_t issue;
	logic [fp_add_pkg::lanes-1:0][31:0] operand_a;
	logic [fp_add_pkg::lanes-1:0][31:0] operand_b;
	fp_add_pkg::issue_t result_issue;
	logic [fp_add_pkg::lanes-1:0][31:0] result;

	expect_t expected[$];
	expect_t head;
	logic [31:0] rng_state = 32'd40;
	logic [31:0] cycle_count = '0;
	logic [7:0] next_tag = '0;
	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int test_start_errors = 0;

	fp_vector_add u_fp_vector_add(
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.result_issue(result_issue),
		.result(result));

	initial
	begin
		clk = 1'b0;
		forever
			#half_period clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Normal operand with exponent 1 to 254
	function automatic logic [31:0] random_normal();
		logic [31:0] r;
		r = next_random();
		return {r[31], 8'(1 + (r[30:23] % 254)), r[22:0]};
	endfunction

	// Exponent within two of word and fraction often near it so sums tend to cancel
	function automatic logic [31:0] random_near(input logic [31:0] word);
		logic [31:0] r;
		int e;
		r = next_random();
		e = int'(word[30:23]) + int'(r[2:0] % 5) - 2;
		e = (e < 1) ? 1 : ((e > 254) ? 254 : e);
		return {r[31], 8'(e), word[22:0] ^ (r[30:8] >> r[7:3])};
	endfunction

	// Model of the add/subtract rule with flush, order, align, add and normalize steps
	function automatic logic [31:0] model_add(input logic [31:0] a, input logic [31:0] b,
		input logic subtract);
		logic sign_a;
		logic sign_b;
		logic b_first;
		logic sign_big;
		int exp_a;
		int exp_b;
		int exp_big;
		int diff;
		int zeros;
		logic [23:0] sig_a;
		logic [23:0] sig_b;
		logic [23:0] sig_big;
		logic [23:0] sig_small;
		logic [24:0] total;
		logic [23:0] shifted;

		sign_a = a[31];
		sign_b = b[31] ^ subtract;
		exp_a = a[30:23];
		exp_b = b[30:23];
		// Zero exponent reads as zero and the denormal fraction is ignored
		sig_a = (exp_a == 0) ? 24'd0 : {1'b1, a[22:0]};
		sig_b = (exp_b == 0) ? 24'd0 : {1'b1, b[22:0]};
		// Larger magnitude first and a keeps a tie
		b_first = (exp_b > exp_a) || ((exp_b == exp_a) && (sig_b > sig_a));
		sign_big = b_first ? sign_b : sign_a;
		exp_big = b_first ? exp_b : exp_a;
		sig_big = b_first ? sig_b : sig_a;
		sig_small = b_first ? sig_a : sig_b;
		diff = b_first ? (exp_b - exp_a) : (exp_a - exp_b);
		sig_small = (diff >= 24) ? 24'd0 : (sig_small >> diff);
		if (sign_a == sign_b)
			total = {1'b0, sig_big} + sig_small;
		else
			total = {1'b0, sig_big} - sig_small;
		// Carry drops the low bit
		if (total[24])
		begin
			total = total >> 1;
			exp_big = exp_big + 1;
		end
		zeros = 24;
		for (int i = 23; i >= 0; i--)
			if (total[i] && (zeros == 24))
				zeros = 23 - i;
		if (total[23:0] == 0)
			return 32'd0;
		if (zeros >= exp_big)
			return {sign_big, 31'd0};
		if (exp_big >= 255)
			return {sign_big, 8'hff, 23'd0};
		shifted = total[23:0] << zeros;
		return {sign_big, 8'(exp_big - zeros), shifted[22:0]};
	endfunction

	task automatic note_failure(input string what);
		$display("%s", what);
		error_count++;
	endtask

	task automatic compare_value(input string name, input logic [31:0] want,
		input logic [31:0] got);
		assert (got == want)
		else
		begin
			$display("Error: %s expected %h actual %h", name, want, got);
			error_count++;
		end
	endtask

	// Drives one issue on the falling edge and queues what should come back
	task automatic send_issue(input fp_add_pkg::fp_op_t op, input logic [3:0] mask,
		input logic [3:0][31:0] a, input logic [3:0][31:0] b);
		expect_t entry;
		@(negedge clk);
		issue.valid = 1'b1;
		issue.op = op;
		issue.mask = mask;
		issue.tag = next_tag;
		operand_a = a;
		operand_b = b;
		entry.tag = next_tag;
		entry.op = op;
		entry.mask = mask;
		entry.cycle = cycle_count;
		for (int i = 0; i < fp_add_pkg::lanes; i++)
			entry.words[i] = mask[i]
				? model_add(a[i], b[i], op == fp_add_pkg::op_subtract) : 0;
		expected.push_back(entry);
		next_tag = next_tag + 1'b1;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		issue.valid = 1'b0;
	endtask

	task automatic begin_test();
		test_start_errors = error_count;
	endtask

	// Waits until every pending issue has come back
	task automatic end_test(input string name);
		idle_cycle();
		while (expected.size() != 0)
			@(negedge clk);
		if (error_count == test_start_errors)
		begin
			tests_passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, error_count - test_start_errors);
		end
	endtask

	// Sampled on the rising edge before that edge's register updates land
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (reset)
		begin
			assert (!result_issue.valid)
			else
				note_failure("result_issue.valid went high during reset");
		end
		else if (result_issue.valid)
		begin
			assert (expected.size() != 0)
			else
				note_failure("result arrived with no pending issue");
			if (expected.size() != 0)
			begin
				head = expected.pop_front();
				compare_value("result_issue.tag", 32'(head.tag), 32'(result_issue.tag));
				compare_value("result_issue.op", 32'(head.op), 32'(result_issue.op));
				compare_value("result_issue.mask", 32'(head.mask), 32'(result_issue.mask));
				for (int i = 0; i < fp_add_pkg::lanes; i++)
					compare_value($sformatf("result[%0d]", i), head.words[i], result[i]);
				assert (cycle_count - head.cycle == latency)
				else
					note_failure($sformatf("tag %0h came back %0d cycles after issue, not 4",
						head.tag, cycle_count - head.cycle));
			end
		end
	end

	initial
	begin
		wait (cycle_count >= timeout_cycles);
		$display("Timeout after %0d cycles with %0d issues still pending",
			cycle_count, expected.size());
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		logic [3:0][31:0] a;
		logic [3:0][31:0] b;
		logic [31:0] r;
		fp_add_pkg::fp_op_t op;

		reset = 1'b1;
		issue = '0;
		operand_a = '0;
		operand_b = '0;

		// Valid low through reset and until four cycles after the first issue
		begin_test();
		repeat (8) @(negedge clk);
		reset = 1'b0;
		a = {4{32'h3f800000}};
		b = {4{32'h40000000}};
		send_issue(fp_add_pkg::op_add, 4'hf, a, b);
		end_test("reset");

		// Lane 0 is the rightmost word
		begin_test();
		a = {32'hbf400000, 32'hc0200000, 32'h40400000, 32'h3fc00000};
		b = {32'hbf400000, 32'h40800000, 32'hbf800000, 32'h40100000};
		send_issue(fp_add_pkg::op_add, 4'hf, a, b);
		a = {32'h40800000, 32'hc0200000, 32'h3fc00000, 32'h40400000};
		b = {32'h3f800000, 32'hc0200000, 32'h40100000, 32'h3f800000};
		send_issue(fp_add_pkg::op_subtract, 4'hf, a, b);
		// Far apart exponents shift the small operand out
		a = {32'h4b800000, 32'h3f800000, 32'hc1200000, 32'h7e000000};
		b = {32'h33800000, 32'hc1200000, 32'h3f800000, 32'h00800000};
		send_issue(fp_add_pkg::op_add, 4'hf, a, b);
		end_test("directed");

		// One fraction bit apart gives a normalization shift of k
		begin_test();
		for (int k = 1; k <= 23; k++)
		begin
			for (int i = 0; i < fp_add_pkg::lanes; i++)
			begin
				a[i] = {i[0], 8'(100 + i), 23'(1) << (23 - k)};
				b[i] = {i[0], 8'(100 + i), 23'd0};
			end
			send_issue(fp_add_pkg::op_subtract, 4'hf, a, b);
		end
		// Equal operands then underflow at exponent 1
		a = {32'hc0490fdb, 32'h40490fdb, 32'h80800001, 32'h00800001};
		b = {32'hc0490fdb, 32'h40490fdb, 32'h80800000, 32'h00800000};
		send_issue(fp_add_pkg::op_subtract, 4'hf, a, b);
		// Overflow at the top and one more underflow
		a = {32'hff7fffff, 32'h7f7fffff, 32'h7f000000, 32'h00c00000};
		b = {32'hff7fffff, 32'h7f7fffff, 32'h7f000000, 32'h80800000};
		send_issue(fp_add_pkg::op_add, 4'hf, a, b);
		end_test("cancellation");

		begin_test();
		for (int n = 0; n < 300; n++)
		begin
			for (int i = 0; i < fp_add_pkg::lanes; i++)
			begin
				a[i] = random_normal();
				r = next_random();
				b[i] = r[0] ? random_near(a[i]) : random_normal();
			end
			r = next_random();
			op = r[0] ? fp_add_pkg::op_subtract : fp_add_pkg::op_add;
			send_issue(op, 4'hf, a, b);
			// Idle gap now and then
			if (r[3:1] == 0)
				idle_cycle();
		end
		end_test("random stream");

		// Random masks with a quarter of the operands denormal
		begin_test();
		for (int n = 0; n < 40; n++)
		begin
			for (int i = 0; i < fp_add_pkg::lanes; i++)
			begin
				r = next_random();
				a[i] = (r[1:0] == 0) ? {r[31], 8'd0, r[30:8]} : random_normal();
				r = next_random();
				b[i] = (r[1:0] == 0) ? {r[31], 8'd0, r[30:8]} : random_near(a[i]);
			end
			r = next_random();
			op = r[0] ? fp_add_pkg::op_subtract : fp_add_pkg::op_add;
			send_issue(op, r[7:4], a, b);
		end
		end_test("mask and denormal");

		$display("Tests passed %0d, failed %0d, errors %0d",
			tests_passed, tests_failed, error_count);
		if ((tests_failed == 0) && (error_count == 0))
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end
endmodule

// File: rtl/fp_vector_add.sv
/*
 Four-lane single precision add/subtract, four cycles from issue to result
 No back-pressure, one issue is accepted every cycle
*/
`timescale 1ns/10ps

module fp_vector_add(
	input                                                       clk,
	input                                                       reset,

	// Issue side
	input fp_add_pkg::issue_t                                   issue,
	input [fp_add_pkg::lanes-1:0][fp_add_pkg::word_width-1:0]   operand_a,
	input [fp_add_pkg::lanes-1:0][fp_add_pkg::word_width-1:0]   operand_b,

	// Result side
	output fp_add_pkg::issue_t                                  result_issue,
	output logic [fp_add_pkg::lanes-1:0][fp_add_pkg::word_width-1:0] result);

	// Align to add
	fp_add_pkg::issue_t align_issue;
	fp_add_pkg::align_lane_t [fp_add_pkg::lanes-1:0] align_lane;

	// Add to leading zero detect
	fp_add_pkg::issue_t sum_issue;
	fp_add_pkg::sum_lane_t [fp_add_pkg::lanes-1:0] sum_lane;

	// Leading zero detect to normalize
	fp_add_pkg::issue_t lzd_issue;
	fp_add_pkg::lzd_lane_t [fp_add_pkg::lanes-1:0] lzd_lane;

	fp_align_stage u_fp_align_stage(
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.align_issue(align_issue),
		.align_lane(align_lane));

	fp_add_stage u_fp_add_stage(
		.clk(clk),
		.reset(reset),
		.align_issue(align_issue),
		.align_lane(align_lane),
		.sum_issue(sum_issue),
		.sum_lane(sum_lane));

	fp_lzd_stage u_fp_lzd_stage(
		.clk(clk),
		.reset(reset),
		.sum_issue(sum_issue),
		.sum_lane(sum_lane),
		.lzd_issue(lzd_issue),
		.lzd_lane(lzd_lane));

	fp_normalize_stage u_fp_normalize_stage(
		.clk(clk),
		.reset(reset),
		.lzd_issue(lzd_issue),
		.lzd_lane(lzd_lane),
		.result_issue(result_issue),
		.result(result));
endmodule

// File: rtl/fp_normalize_stage.sv
/*
 Underflow flushes to signed zero and exact cancellation gives +0
 Overflow gives signed infinity, lanes with a clear mask bit return 0
*/
`timescale 1ns/10ps

module fp_normalize_stage(
	input                                                       clk,
	input                                                       reset,

	// From leading zero detect
	input fp_add_pkg::issue_t                                   lzd_issue,
	input fp_add_pkg::lzd_lane_t [fp_add_pkg::lanes-1:0]        lzd_lane,

	// Packed results
	output fp_add_pkg::issue_t                                  result_issue,
	output logic [fp_add_pkg::lanes-1:0][fp_add_pkg::word_width-1:0] result);

	genvar lane_idx;
	generate
		for (lane_idx = 0; lane_idx < fp_add_pkg::lanes; lane_idx++)
		begin : lane_logic
			logic [fp_add_pkg::sig_width-1:0] shifted_sig;
			logic [fp_add_pkg::exp_width-1:0] norm_exp;
			logic [fp_add_pkg::word_width-1:0] word_nxt;

			// Leading one lands in the hidden bit position
			assign shifted_sig = lzd_lane[lane_idx].significand << lzd_lane[lane_idx].norm_shift;
			assign norm_exp = lzd_lane[lane_idx].exponent - lzd_lane[lane_idx].norm_shift;

			always_comb
			begin
				if (!lzd_issue.mask[lane_idx])
					word_nxt = '0;
				// Zero sum is always positive
				else if (lzd_lane[lane_idx].significand == '0)
					word_nxt = '0;
				// Would need exponent 0 or below
				else if (lzd_lane[lane_idx].norm_shift >= lzd_lane[lane_idx].exponent)
					word_nxt = {lzd_lane[lane_idx].sign, {(fp_add_pkg::word_width - 1){1'b0}}};
				// Saturated exponent, only an add can carry this far
				else if (!lzd_lane[lane_idx].logical_subtract
					&& (lzd_lane[lane_idx].exponent == '1))
					word_nxt = {lzd_lane[lane_idx].sign, {fp_add_pkg::exp_width{1'b1}},
						{fp_add_pkg::frac_width{1'b0}}};
				else
					word_nxt = {lzd_lane[lane_idx].sign, norm_exp,
						shifted_sig[fp_add_pkg::frac_width-1:0]};
			end

			always_ff @(posedge clk)
			begin
				result[lane_idx] <= word_nxt;
			end
		end
	endgenerate

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			result_issue <= '0;
		else
			result_issue <= lzd_issue;
	end
endmodule

// File: rtl/fp_lzd_stage.sv
/*
 Normalization shift is the leading zero count of the 24-bit sum
 A shift of 24 means the sum is zero
*/
`timescale 1ns/10ps

module fp_lzd_stage(
	input                                                  clk,
	input                                                  reset,

	// From add stage
	input fp_add_pkg::issue_t                              sum_issue,
	input fp_add_pkg::sum_lane_t [fp_add_pkg::lanes-1:0]   sum_lane,

	// To normalize stage
	output fp_add_pkg::issue_t                             lzd_issue,
	output fp_add_pkg::lzd_lane_t [fp_add_pkg::lanes-1:0]  lzd_lane);

	genvar lane_idx;
	generate
		for (lane_idx = 0; lane_idx < fp_add_pkg::lanes; lane_idx++)
		begin : lane_logic
			logic [fp_add_pkg::shift_width-1:0] norm_shift_nxt;

			// Priority encoder, higher bits overwrite lower ones
			always_comb
			begin
				norm_shift_nxt = fp_add_pkg::zero_sum_shift;
				for (int bit_idx = 0; bit_idx < fp_add_pkg::sig_width; bit_idx++)
				begin
					if (sum_lane[lane_idx].sum[bit_idx])
						norm_shift_nxt = fp_add_pkg::shift_width'(
							fp_add_pkg::sig_width - 1 - bit_idx);
				end
			end

			// Sum moves along with its shift unchanged
			always_ff @(posedge clk)
			begin
				lzd_lane[lane_idx].sign <= sum_lane[lane_idx].sign;
				lzd_lane[lane_idx].logical_subtract <= sum_lane[lane_idx].logical_subtract;
				lzd_lane[lane_idx].exponent <= sum_lane[lane_idx].exponent;
				lzd_lane[lane_idx].significand <= sum_lane[lane_idx].sum;
				lzd_lane[lane_idx].norm_shift <= norm_shift_nxt;
			end
		end
	endgenerate

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			lzd_issue <= '0;
		else
			lzd_issue <= sum_issue;
	end
endmodule

// File: rtl/fp_add_stage.sv
/*
 Expects the larger significand first, so a subtract never borrows
 A carry out loses its low bit, and the exponent saturates at 255 to flag overflow
*/
`timescale 1ns/10ps

module fp_add_stage(
	input                                                    clk,
	input                                                    reset,

	// From align stage
	input fp_add_pkg::issue_t                                align_issue,
	input fp_add_pkg::align_lane_t [fp_add_pkg::lanes-1:0]   align_lane,

	// To leading zero detect
	output fp_add_pkg::issue_t                               sum_issue,
	output fp_add_pkg::sum_lane_t [fp_add_pkg::lanes-1:0]    sum_lane);

	genvar lane_idx;
	generate
		for (lane_idx = 0; lane_idx < fp_add_pkg::lanes; lane_idx++)
		begin : lane_logic
			// One extra bit holds the carry
			logic [fp_add_pkg::sig_width:0] raw_sum;
			fp_add_pkg::sum_lane_t lane_nxt;

			always_comb
			begin
				lane_nxt.sign = align_lane[lane_idx].sign;
				lane_nxt.logical_subtract = align_lane[lane_idx].logical_subtract;

				// Effective signs pick add or subtract
				if (align_lane[lane_idx].logical_subtract)
					raw_sum = {1'b0, align_lane[lane_idx].large_sig}
						- {1'b0, align_lane[lane_idx].small_sig};
				else
					raw_sum = {1'b0, align_lane[lane_idx].large_sig}
						+ {1'b0, align_lane[lane_idx].small_sig};

				if (raw_sum[fp_add_pkg::sig_width])
				begin
					// Carry out, renormalize by one and bump the exponent
					lane_nxt.sum = raw_sum[fp_add_pkg::sig_width:1];
					if (align_lane[lane_idx].exponent == '1)
						lane_nxt.exponent = '1;
					else
						lane_nxt.exponent = align_lane[lane_idx].exponent + 1'b1;
				end
				else
				begin
					lane_nxt.sum = raw_sum[fp_add_pkg::sig_width-1:0];
					lane_nxt.exponent = align_lane[lane_idx].exponent;
				end
			end

			always_ff @(posedge clk)
			begin
				sum_lane[lane_idx] <= lane_nxt;
			end
		end
	endgenerate

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			sum_issue <= '0;
		else
			sum_issue <= align_issue;
	end
endmodule

// File: rtl/fp_align_stage.sv
/*
 Operands with a zero exponent are flushed to zero, exponent 255 is not expected
 Alignment truncates, bits shifted past the significand are lost
*/
`timescale 1ns/10ps

module fp_align_stage(
	input                                                      clk,
	input                                                      reset,

	// From issue
	input fp_add_pkg::issue_t                                  issue,
	input [fp_add_pkg::lanes-1:0][fp_add_pkg::word_width-1:0]  operand_a,
	input [fp_add_pkg::lanes-1:0][fp_add_pkg::word_width-1:0]  operand_b,

	// To add stage
	output fp_add_pkg::issue_t                                 align_issue,
	output fp_add_pkg::align_lane_t [fp_add_pkg::lanes-1:0]    align_lane);

	genvar lane_idx;
	generate
		for (lane_idx = 0; lane_idx < fp_add_pkg::lanes; lane_idx++)
		begin : lane_logic
			logic sign_a;
			logic sign_b;
			logic [fp_add_pkg::exp_width-1:0] exp_a;
			logic [fp_add_pkg::exp_width-1:0] exp_b;
			logic [fp_add_pkg::sig_width-1:0] sig_a;
			logic [fp_add_pkg::sig_width-1:0] sig_b;
			logic a_larger;
			logic [fp_add_pkg::exp_width-1:0] exp_diff;
			logic [fp_add_pkg::sig_width-1:0] small_sig;
			fp_add_pkg::align_lane_t lane_nxt;

			// Unpack, a zero exponent makes the significand zero too
			assign sign_a = operand_a[lane_idx][fp_add_pkg::word_width-1];
			assign exp_a = operand_a[lane_idx][fp_add_pkg::frac_width +: fp_add_pkg::exp_width];
			assign sig_a = (exp_a == '0) ? '0
				: {1'b1, operand_a[lane_idx][fp_add_pkg::frac_width-1:0]};

			// Subtract becomes an add of b with its sign flipped
			assign sign_b = operand_b[lane_idx][fp_add_pkg::word_width-1]
				^ (issue.op == fp_add_pkg::op_subtract);
			assign exp_b = operand_b[lane_idx][fp_add_pkg::frac_width +: fp_add_pkg::exp_width];
			assign sig_b = (exp_b == '0) ? '0
				: {1'b1, operand_b[lane_idx][fp_add_pkg::frac_width-1:0]};

			// Magnitude compare, exponent first, a wins a tie
			assign a_larger = (exp_a > exp_b) || ((exp_a == exp_b) && (sig_a >= sig_b));

			always_comb
			begin
				lane_nxt.logical_subtract = sign_a ^ sign_b;

				// Larger operand goes first and sets sign and exponent
				if (a_larger)
				begin
					lane_nxt.sign = sign_a;
					lane_nxt.exponent = exp_a;
					lane_nxt.large_sig = sig_a;
					small_sig = sig_b;
					exp_diff = exp_a - exp_b;
				end
				else
				begin
					lane_nxt.sign = sign_b;
					lane_nxt.exponent = exp_b;
					lane_nxt.large_sig = sig_b;
					small_sig = sig_a;
					exp_diff = exp_b - exp_a;
				end

				// Saturate, a difference of 24 or more leaves nothing
				if (exp_diff >= fp_add_pkg::sig_width)
					lane_nxt.small_sig = '0;
				else
					lane_nxt.small_sig = small_sig >> exp_diff;
			end

			always_ff @(posedge clk)
			begin
				align_lane[lane_idx] <= lane_nxt;
			end
		end
	endgenerate

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			align_issue <= '0;
		else
			align_issue <= issue;
	end
endmodule

// File: rtl/fp_add_pkg.sv
/*
 Lane count, IEEE single precision field widths and the payloads passed between stages
 Only normal single precision operands are described, NaN and infinity have no encoding here
*/
package fp_add_pkg;
	// Vector shape
	localparam int lanes = 4;
	localparam int word_width = 32;

	// IEEE single precision fields
	localparam int exp_width = 8;
	localparam int frac_width = 23;
	// Significand including the hidden bit
	localparam int sig_width = frac_width + 1;

	// Normalization shift covers 0 through 24
	localparam int shift_width = 5;
	// Shift reported for an all-zero sum
	localparam logic [shift_width-1:0] zero_sum_shift = shift_width'(sig_width);

	typedef enum logic
	{
		op_add,
		op_subtract
	} fp_op_t;

	// Sideband that rides next to the lane data through every stage
	typedef struct packed
	{
		logic valid;
		fp_op_t op;
		logic [lanes-1:0] mask;
		logic [7:0] tag;
	} issue_t;

	// Align to add: operands ordered by magnitude, small one already shifted
	typedef struct packed
	{
		logic sign;
		logic logical_subtract;
		logic [exp_width-1:0] exponent;
		logic [sig_width-1:0] large_sig;
		logic [sig_width-1:0] small_sig;
	} align_lane_t;

	// Add to leading zero detect
	typedef struct packed
	{
		logic sign;
		logic logical_subtract;
		logic [exp_width-1:0] exponent;
		logic [sig_width-1:0] sum;
	} sum_lane_t;

	// Leading zero detect to normalize
	typedef struct packed
	{
		logic sign;
		logic logical_subtract;
		logic [exp_width-1:0] exponent;
		logic [sig_width-1:0] significand;
		logic [shift_width-1:0] norm_shift;
	} lzd_lane_t;
endpackage
